//--- source/renkon_pkg.sv
package renkon_pkg;

  // ==================================================
  // widths and sizes
  // ==================================================
  localparam int data_width        = 16;
  localparam int len_width         = 8;
  localparam int mem_addr_width    = 12;
  localparam int net_addr_width    = 10;
  localparam int core_count        = 4;
  localparam int core_sel_width    = 2;
  localparam int serial_addr_width = 8;

  typedef enum logic [1:0] {
    phase_wait    = 2'd0,
    phase_network = 2'd1,
    phase_input   = 2'd2,
    phase_output  = 2'd3
  } phase_t;

  // raw layer request as driven from outside
  typedef struct packed {
    logic [len_width-1:0] total_in;
    logic [len_width-1:0] total_out;
    logic [len_width-1:0] img_height;
    logic [len_width-1:0] img_width;
    logic [len_width-1:0] conv_kern;
    logic [len_width-1:0] conv_pad;
  } layer_param_t;

  typedef struct packed {
    layer_param_t         layer;
    logic [len_width-1:0] fea_height;
    logic [len_width-1:0] fea_width;
  } job_param_t;

  typedef struct packed {
    logic [mem_addr_width-1:0] in_offset;
    logic [mem_addr_width-1:0] out_offset;
    logic [net_addr_width-1:0] net_offset;
  } mem_offset_t;

endpackage

//--- source/renkon_param_decode.sv
module renkon_param_decode
  import renkon_pkg::*;
  ( input                clk
  , input                xrst
  , input                req
  , input  phase_t       phase
  , input  layer_param_t param
  , input  mem_offset_t  offset
  , output logic         start
  , output job_param_t   job
  , output mem_offset_t  offset_q
  );

  logic                 req_q;
  logic [len_width-1:0] pad_both;

  // rising edge of the request level
  assign start = req && !req_q;

  // padding on both sides of the image
  assign pad_both = param.conv_pad << 1;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      req_q <= 1'b0;
    end
    else begin
      req_q <= req;
    end
  end

  // capture only while idle, so a stray edge mid-job is ignored
  always_ff @(posedge clk) begin
    if (!xrst) begin
      job      <= '0;
      offset_q <= '0;
    end
    else if (start && phase == phase_wait) begin
      job.layer      <= param;
      job.fea_height <= param.img_height + pad_both - param.conv_kern + len_width'(1);
      job.fea_width  <= param.img_width + pad_both - param.conv_kern + len_width'(1);
      offset_q       <= offset;
    end
  end

endmodule

//--- source/renkon_phase_ctrl.sv
module renkon_phase_ctrl
  import renkon_pkg::*;
  ( input              clk
  , input              xrst
  , input              start
  , input  job_param_t job
  , input              net_end
  , input              input_end
  , input              output_end
  , output phase_t     phase
  , output logic       last_channel
  , output logic       final_group
  , output logic       first_input
  , output logic       last_input
  , output logic       ack
  );

  logic [len_width-1:0] count_in;
  logic [len_width-1:0] count_out;

  assign last_channel = count_in == job.layer.total_in - len_width'(1);

  // one bit wider so the group base cannot wrap
  assign final_group = {1'b0, count_out} + (len_width+1)'(core_count)
                    >= {1'b0, job.layer.total_out};

  // ==================================================
  // main phase machine
  // ==================================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      phase     <= phase_wait;
      count_in  <= '0;
      count_out <= '0;
    end
    else begin
      case (phase)
        phase_wait:
          if (start)
            phase <= phase_network;
        phase_network:
          if (net_end)
            phase <= phase_input;
        phase_input:
          if (input_end) begin
            if (last_channel) begin
              phase    <= phase_output;
              count_in <= '0;
            end
            else begin
              phase    <= phase_network;
              count_in <= count_in + len_width'(1);
            end
          end
        phase_output:
          if (output_end) begin
            if (final_group) begin
              phase     <= phase_wait;
              count_out <= '0;
            end
            else begin
              phase     <= phase_network;
              count_out <= count_out + len_width'(core_count);
            end
          end
        default:
          phase <= phase_wait;
      endcase
    end
  end

  // ==================================================
  // channel flags and ack
  // ==================================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      first_input <= 1'b0;
      last_input  <= 1'b0;
    end
    else begin
      first_input <= phase == phase_input && count_in == '0;
      last_input  <= phase == phase_input && last_channel;
    end
  end

  // idle high, low for the whole job
  always_ff @(posedge clk) begin
    if (!xrst) begin
      ack <= 1'b1;
    end
    else if (start && phase == phase_wait) begin
      ack <= 1'b0;
    end
    else if (output_end && final_group) begin
      ack <= 1'b1;
    end
  end

endmodule

//--- source/renkon_net_addr.sv
module renkon_net_addr
  import renkon_pkg::*;
  ( input                             clk
  , input                             xrst
  , input  phase_t                    phase
  , input  job_param_t                job
  , input  mem_offset_t               offset_q
  , input                             last_channel
  , input                             final_group
  , input                             net_we
  , input        [core_sel_width-1:0] net_sel
  , input        [net_addr_width-1:0] net_addr
  , output logic                      net_end
  , output logic                      wreg_we
  , output logic                      breg_we
  , output logic [core_count-1:0]     mem_net_we
  , output logic [net_addr_width-1:0] mem_net_addr
  );

  logic                      in_bias;
  logic                      weight_end;
  logic [len_width-1:0]      weight_x;
  logic [len_width-1:0]      weight_y;
  logic [net_addr_width-1:0] net_count;

  assign weight_end = phase == phase_network && !in_bias
                   && weight_x == job.layer.conv_kern - len_width'(1)
                   && weight_y == job.layer.conv_kern - len_width'(1);

  // the last channel also fetches one bias word
  assign net_end = last_channel ? phase == phase_network && in_bias : weight_end;

  // ==================================================
  // weight window and bias step
  // ==================================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      in_bias  <= 1'b0;
      weight_x <= '0;
      weight_y <= '0;
    end
    else if (phase != phase_network || in_bias) begin
      in_bias  <= 1'b0;
      weight_x <= '0;
      weight_y <= '0;
    end
    else begin
      in_bias <= weight_end && last_channel;
      if (weight_x == job.layer.conv_kern - len_width'(1)) begin
        weight_x <= '0;
        weight_y <= weight_end ? '0 : weight_y + len_width'(1);
      end
      else begin
        weight_x <= weight_x + len_width'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wreg_we <= 1'b0;
      breg_we <= 1'b0;
    end
    else begin
      wreg_we <= phase == phase_network && !in_bias;
      breg_we <= phase == phase_network && in_bias;
    end
  end

  // running net address, one word per weight or bias write
  always_ff @(posedge clk) begin
    if (!xrst) begin
      net_count <= '0;
    end
    else if (breg_we && final_group) begin
      net_count <= '0;
    end
    else if (wreg_we || breg_we) begin
      net_count <= net_count + net_addr_width'(1);
    end
  end

  // external load port overrides the fetch address
  always_comb begin
    for (int i = 0; i < core_count; i++) begin
      mem_net_we[i] = net_we && net_sel == core_sel_width'(i);
    end
  end

  assign mem_net_addr = net_we ? net_addr : offset_q.net_offset + net_count;

endmodule

//--- source/renkon_img_addr.sv
module renkon_img_addr
  import renkon_pkg::*;
  ( input                             clk
  , input                             xrst
  , input  phase_t                    phase
  , input  job_param_t                job
  , input  mem_offset_t               offset_q
  , input                             last_channel
  , input                             output_end
  , input                             img_we
  , output logic                      input_end
  , output logic                      pix_re
  , output logic [mem_addr_width-1:0] img_addr
  );

  logic                      scan_last;
  logic                      was_wait;
  logic [len_width-1:0]      scan_x;
  logic [len_width-1:0]      scan_y;
  logic [mem_addr_width-1:0] out_count;

  assign pix_re    = phase == phase_input;
  assign scan_last = scan_x == job.layer.img_width - len_width'(1)
                  && scan_y == job.layer.img_height - len_width'(1);
  assign input_end = pix_re && scan_last;

  // pixel scan, x first
  always_ff @(posedge clk) begin
    if (!xrst) begin
      scan_x <= '0;
      scan_y <= '0;
    end
    else if (!pix_re) begin
      scan_x <= '0;
      scan_y <= '0;
    end
    else if (scan_x == job.layer.img_width - len_width'(1)) begin
      scan_x <= '0;
      scan_y <= scan_last ? '0 : scan_y + len_width'(1);
    end
    else begin
      scan_x <= scan_x + len_width'(1);
    end
  end

  // words written back so far in this job
  always_ff @(posedge clk) begin
    if (!xrst) begin
      was_wait  <= 1'b1;
      out_count <= '0;
    end
    else begin
      was_wait <= phase == phase_wait;
      if (was_wait) begin
        out_count <= '0;
      end
      else if (img_we) begin
        out_count <= out_count + mem_addr_width'(1);
      end
    end
  end

  // offsets are valid one cycle after the job starts
  always_ff @(posedge clk) begin
    if (!xrst) begin
      img_addr <= '0;
    end
    else if (was_wait || output_end) begin
      img_addr <= offset_q.in_offset;
    end
    else if (input_end && last_channel) begin
      img_addr <= offset_q.out_offset + out_count;
    end
    else if (pix_re || img_we) begin
      img_addr <= img_addr + mem_addr_width'(1);
    end
  end

endmodule

//--- source/renkon_out_serial.sv
module renkon_out_serial
  import renkon_pkg::*;
  ( input                                clk
  , input                                xrst
  , input  phase_t                       phase
  , input  job_param_t                   job
  , input        [data_width-1:0]        out_wdata
  , output logic                         output_end
  , output logic [core_sel_width:0]      serial_re
  , output logic [serial_addr_width-1:0] serial_addr
  , output logic                         img_we
  , output logic [data_width-1:0]        img_wdata
  );

  logic                         reading;
  logic                         done;
  logic                         last_core;
  logic                         last_read;
  logic [core_sel_width-1:0]    core_idx;
  logic [serial_addr_width-1:0] last_addr;

  // words per result buffer, minus one
  assign last_addr = serial_addr_width'(job.fea_height * job.fea_width - 1);
  assign last_core = core_idx == core_sel_width'(core_count - 1);
  assign last_read = reading && last_core && serial_addr == last_addr;

  // core select, zero when idle
  assign serial_re = reading ? {1'b0, core_idx} + (core_sel_width+1)'(1) : '0;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      reading     <= 1'b0;
      done        <= 1'b0;
      core_idx    <= '0;
      serial_addr <= '0;
    end
    else if (phase != phase_output) begin
      reading     <= 1'b0;
      done        <= 1'b0;
      core_idx    <= '0;
      serial_addr <= '0;
    end
    else if (!reading && !done) begin
      reading <= 1'b1;
    end
    else if (reading) begin
      if (serial_addr == last_addr) begin
        serial_addr <= '0;
        if (last_core) begin
          reading  <= 1'b0;
          done     <= 1'b1;
          core_idx <= '0;
        end
        else begin
          core_idx <= core_idx + core_sel_width'(1);
        end
      end
      else begin
        serial_addr <= serial_addr + serial_addr_width'(1);
      end
    end
  end

  // write back one cycle behind each read
  always_ff @(posedge clk) begin
    if (!xrst) begin
      img_we     <= 1'b0;
      output_end <= 1'b0;
    end
    else begin
      img_we     <= reading;
      output_end <= last_read;
    end
  end

  always_ff @(posedge clk) begin
    img_wdata <= out_wdata;
  end

endmodule

//--- source/renkon_ctrl_core.sv
module renkon_ctrl_core
  import renkon_pkg::*;
  ( input                                clk
  , input                                xrst
  , input                                req
  , input  layer_param_t                 param
  , input  mem_offset_t                  offset
  , input        [data_width-1:0]        out_wdata
  , input                                net_we
  , input        [core_sel_width-1:0]    net_sel
  , input        [net_addr_width-1:0]    net_addr
  , output logic                         ack
  , output phase_t                       phase
  , output logic                         first_input
  , output logic                         last_input
  , output logic                         wreg_we
  , output logic                         breg_we
  , output logic [core_count-1:0]        mem_net_we
  , output logic [net_addr_width-1:0]    mem_net_addr
  , output logic                         pix_re
  , output logic                         img_we
  , output logic [mem_addr_width-1:0]    img_addr
  , output logic [data_width-1:0]        img_wdata
  , output logic [core_sel_width:0]      serial_re
  , output logic [serial_addr_width-1:0] serial_addr
  );

  logic        start;
  logic        net_end;
  logic        input_end;
  logic        output_end;
  logic        last_channel;
  logic        final_group;
  job_param_t  job;
  mem_offset_t offset_q;

  // ==================================================
  // decode
  // ==================================================
  renkon_param_decode decode (.*);

  // ==================================================
  // execute
  // ==================================================
  renkon_phase_ctrl phase_ctrl (.*);

  renkon_net_addr net_addr_gen (.*);

  // ==================================================
  // result
  // ==================================================
  renkon_img_addr img_addr_gen (.*);

  renkon_out_serial out_serial (.*);

endmodule

//--- verification/tb_renkon_ctrl_core.sv
module tb_renkon_ctrl_core
  import renkon_pkg::*;
  ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int job_count = 6;

  logic                         clk;
  logic                         xrst;
  logic                         req;
  layer_param_t                 param;
  mem_offset_t                  offset;
  logic [data_width-1:0]        out_wdata;
  logic                         net_we;
  logic [core_sel_width-1:0]    net_sel;
  logic [net_addr_width-1:0]    net_addr;
  logic                         ack;
  phase_t                       phase;
  logic                         first_input;
  logic                         last_input;
  logic                         wreg_we;
  logic                         breg_we;
  logic [core_count-1:0]        mem_net_we;
  logic [net_addr_width-1:0]    mem_net_addr;
  logic                         pix_re;
  logic                         img_we;
  logic [mem_addr_width-1:0]    img_addr;
  logic [data_width-1:0]        img_wdata;
  logic [core_sel_width:0]      serial_re;
  logic [serial_addr_width-1:0] serial_addr;

  logic [31:0]  lfsr;
  int           cycles = 0;
  int           limit = 0;
  int           value_errors = 0;
  int           other_errors = 0;
  layer_param_t job_param [job_count];
  mem_offset_t  job_offset [job_count];
  int           job_burst [job_count];

  // reference model state for the running job
  mem_offset_t cur_offset;
  int          cur_k;
  int          cur_h;
  int          cur_w;
  int          cur_tin;
  int          cur_groups;
  int          cur_fea = 1;
  int          channel = 0;
  int          wcount = 0;
  int          bcount = 0;
  int          net_ptr = 0;
  int          pix_idx = 0;
  int          pix_total = 0;
  int          wr_idx = 0;
  int          sidx = 0;
  int          groups_done = 0;
  logic        exp_first = 1'b0;
  logic        exp_last = 1'b0;
  phase_t      prev_phase = phase_wait;

  renkon_ctrl_core i_renkon_ctrl_core (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==================================================
  // random numbers and model helpers
  // ==================================================
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'(rand_bits(8) % (hi - lo + 1));
  endfunction

  function automatic int feature_len(input int len, input int pad, input int kern);
    return len + 2 * pad - kern + 1;
  endfunction

  // generous cycle count for one job
  function automatic int job_bound(input layer_param_t p);
    int k;
    int f;
    int groups;
    k = int'(p.conv_kern);
    f = feature_len(int'(p.img_height), int'(p.conv_pad), k)
      * feature_len(int'(p.img_width), int'(p.conv_pad), k);
    groups = (int'(p.total_out) + core_count - 1) / core_count;
    return groups * (int'(p.total_in) * (k * k + int'(p.img_height) * int'(p.img_width) + 4)
                     + core_count * f + 4) + 16;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("error %s: expected %0d, actual %0d at cycle %0d", name, expected, actual, cycles);
    value_errors++;
  endtask

  task automatic report_failure(input string what);
    $display("failure at cycle %0d: %s", cycles, what);
    other_errors++;
  endtask

  // ==================================================
  // per-cycle checks sampled before the next drive
  // ==================================================
  task automatic check_outputs();
    logic [core_count-1:0] onehot;
    logic [31:0]           expect_val;
    onehot = '0;
    if (net_we) begin
      onehot[net_sel] = 1'b1;
      if (mem_net_we !== onehot)
        report_mismatch("net_load_we", 32'(onehot), 32'(mem_net_we));
      if (mem_net_addr !== net_addr)
        report_mismatch("net_load_addr", 32'(net_addr), 32'(mem_net_addr));
    end
    else if (mem_net_we !== '0) begin
      report_failure("net memory write without net_we");
    end
    if (phase == phase_wait && (wreg_we || breg_we || pix_re || img_we || serial_re != '0))
      report_failure("strobe active in the wait phase");
    if ((phase == phase_wait) != (ack == 1'b1))
      report_failure("ack does not match the idle state");
    // weights and bias share one consecutive net address stream
    if (wreg_we || breg_we) begin
      expect_val = 32'(net_addr_width'(cur_offset.net_offset + net_ptr));
      if (32'(mem_net_addr) !== expect_val) begin
        if (wreg_we)
          report_mismatch("weight_addr", expect_val, 32'(mem_net_addr));
        else
          report_mismatch("bias_addr", expect_val, 32'(mem_net_addr));
      end
      net_ptr++;
      if (wreg_we)
        wcount++;
      else
        bcount++;
    end
    if (pix_re) begin
      if (phase != phase_input)
        report_failure("pix_re outside the input phase");
      expect_val = 32'(mem_addr_width'(cur_offset.in_offset + pix_idx));
      if (32'(img_addr) !== expect_val)
        report_mismatch("read_addr", expect_val, 32'(img_addr));
      pix_idx++;
      pix_total++;
    end
    if (img_we) begin
      expect_val = 32'(mem_addr_width'(cur_offset.out_offset + wr_idx));
      if (32'(img_addr) !== expect_val)
        report_mismatch("write_addr", expect_val, 32'(img_addr));
      // out_wdata still holds last cycle's drive
      if (img_wdata !== out_wdata)
        report_mismatch("write_data", 32'(out_wdata), 32'(img_wdata));
      wr_idx++;
    end
    if (serial_re != '0) begin
      expect_val = 32'(sidx / cur_fea + 1);
      if (32'(serial_re) !== expect_val)
        report_mismatch("serial_re", expect_val, 32'(serial_re));
      expect_val = 32'(sidx % cur_fea);
      if (32'(serial_addr) !== expect_val)
        report_mismatch("serial_addr", expect_val, 32'(serial_addr));
      sidx++;
    end
    if (first_input !== exp_first)
      report_mismatch("first_input", 32'(exp_first), 32'(first_input));
    if (last_input !== exp_last)
      report_mismatch("last_input", 32'(exp_last), 32'(last_input));
    // end of one channel iteration
    if (prev_phase == phase_input && phase != phase_input) begin
      if (wcount != cur_k * cur_k)
        report_mismatch("weight_count", cur_k * cur_k, wcount);
      if (bcount != (channel == cur_tin - 1 ? 1 : 0))
        report_mismatch("bias_count", (channel == cur_tin - 1 ? 1 : 0), bcount);
      if ((phase == phase_output) != (channel == cur_tin - 1))
        report_failure("wrong phase after an input phase");
      wcount = 0;
      bcount = 0;
      channel = phase == phase_output ? 0 : channel + 1;
    end
    // end of one output group
    if (prev_phase == phase_output && phase != phase_output) begin
      if (sidx != core_count * cur_fea)
        report_mismatch("serial_reads", core_count * cur_fea, sidx);
      sidx = 0;
      pix_idx = 0;
      groups_done++;
    end
    exp_first  = phase == phase_input && channel == 0;
    exp_last   = phase == phase_input && channel == cur_tin - 1;
    prev_phase = phase;
  endtask

  task automatic tick();
    @(negedge clk);
    check_outputs();
    cycles++;
    out_wdata = data_width'(rand_bits(data_width));
  endtask

  // ==================================================
  // one job with its preceding net load burst
  // ==================================================
  task automatic run_job(input int j);
    for (int i = 0; i < job_burst[j]; i++) begin
      net_we   = 1'b1;
      net_sel  = core_sel_width'(rand_bits(core_sel_width));
      net_addr = net_addr_width'(rand_bits(net_addr_width));
      tick();
    end
    net_we     = 1'b0;
    cur_offset = job_offset[j];
    cur_k      = int'(job_param[j].conv_kern);
    cur_h      = int'(job_param[j].img_height);
    cur_w      = int'(job_param[j].img_width);
    cur_tin    = int'(job_param[j].total_in);
    cur_fea    = feature_len(cur_h, int'(job_param[j].conv_pad), cur_k)
               * feature_len(cur_w, int'(job_param[j].conv_pad), cur_k);
    cur_groups = (int'(job_param[j].total_out) + core_count - 1) / core_count;
    net_ptr     = 0;
    pix_total   = 0;
    wr_idx      = 0;
    groups_done = 0;
    param  = job_param[j];
    offset = job_offset[j];
    req    = 1'b1;
    tick();
    if (ack !== 1'b0)
      report_mismatch("ack_fall", 0, 32'(ack));
    // the running job works from the latched copy only
    param  = layer_param_t'(~job_param[j]);
    offset = mem_offset_t'(~job_offset[j]);
    while (ack !== 1'b1)
      tick();
    if (phase != phase_wait)
      report_failure("phase did not return to wait at ack");
    if (groups_done != cur_groups)
      report_mismatch("group_count", cur_groups, groups_done);
    if (pix_total != cur_groups * cur_tin * cur_h * cur_w)
      report_mismatch("read_count", cur_groups * cur_tin * cur_h * cur_w, pix_total);
    if (wr_idx != cur_groups * core_count * cur_fea)
      report_mismatch("write_count", cur_groups * core_count * cur_fea, wr_idx);
    if (net_ptr != cur_groups * (cur_tin * cur_k * cur_k + 1))
      report_mismatch("net_fetch_count", cur_groups * (cur_tin * cur_k * cur_k + 1), net_ptr);
    // a request level still high when idle must not start another job
    tick();
    if (ack !== 1'b1)
      report_failure("a held request started another job");
    req = 1'b0;
  endtask

  initial begin
    xrst      = 1'b0;
    req       = 1'b0;
    param     = '0;
    offset    = '0;
    out_wdata = '0;
    net_we    = 1'b0;
    net_sel   = '0;
    net_addr  = '0;
    lfsr      = 32'hdcd2;
    for (int j = 0; j < job_count; j++) begin
      job_param[j].conv_kern  = len_width'(rand_range(1, 3));
      job_param[j].conv_pad   = len_width'(rand_range(0, 1));
      job_param[j].img_height = len_width'(rand_range(3, 6));
      job_param[j].img_width  = len_width'(rand_range(3, 6));
      job_param[j].total_in   = len_width'(rand_range(1, 3));
      job_param[j].total_out  = len_width'(rand_range(1, 6));
      job_offset[j].in_offset  = mem_addr_width'(rand_bits(mem_addr_width));
      job_offset[j].out_offset = mem_addr_width'(rand_bits(mem_addr_width));
      job_offset[j].net_offset = net_addr_width'(rand_bits(net_addr_width));
      job_burst[j] = rand_range(1, 6);
    end
    for (int j = 0; j < job_count; j++)
      limit += job_bound(job_param[j]) + job_burst[j];
    limit += 100;
    repeat (8) @(negedge clk);
    xrst = 1'b1;
    tick();
    if (ack !== 1'b1)
      report_mismatch("ack_reset", 1, 32'(ack));
    for (int j = 0; j < job_count; j++)
      run_job(j);
    repeat (4) tick();
    $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // watchdog on the cycle count of all jobs
  initial begin
    wait (limit > 0 && cycles >= limit);
    $display("timeout: the run went past its limit of %0d cycles", limit);
    $display("Test failed");
    $finish;
  end

endmodule

//--- build.f
source/renkon_pkg.sv
source/renkon_param_decode.sv
source/renkon_phase_ctrl.sv
source/renkon_net_addr.sv
source/renkon_img_addr.sv
source/renkon_out_serial.sv
source/renkon_ctrl_core.sv
verification/tb_renkon_ctrl_core.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, then scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing -f build.f --top-module tb_renkon_ctrl_core -o sim_renkon
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/sim_renkon > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
